//--- rtl/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// 64 lines per bank
`define ICACHE_INDEX_BITS 6

`define ICACHE_ADDR_BITS 32

// address minus index minus the 16-byte tile offset
`define ICACHE_TAG_BITS (`ICACHE_ADDR_BITS - `ICACHE_INDEX_BITS - 4)

`define ICACHE_TILE_BITS 128
`define ICACHE_HALF_BITS (`ICACHE_TILE_BITS / 2)

// Set to 1'b1 to decode the 48-bit instruction form (111x01 prefix).
`define ICACHE_OPS48 1'b0

`endif

//--- rtl/icachePkg.sv
`include "icache_params.svh"

package icachePkg;

	typedef enum logic [1:0]
	{
		statusHold  = 2'd0,	// miss in progress
		statusOk    = 2'd1,
		statusFault = 2'd2	// bus error on refill
	} fetchStatusT;

	// classic read only with we held low
	typedef struct packed
	{
		logic                          cyc;
		logic                          stb;
		logic [`ICACHE_ADDR_BITS-1:0]  adr;
	} wbReqT;

	typedef struct packed
	{
		logic                          ack;
		logic                          err;
		logic [`ICACHE_TILE_BITS-1:0]  dat;	// one whole tile
	} wbRspT;

	typedef struct packed
	{
		logic [`ICACHE_HALF_BITS-1:0]  hi;	// odd bank half
		logic [`ICACHE_HALF_BITS-1:0]  lo;	// even bank half
	} tileHalvesT;

	// same tile seen as bank halves or as instruction words
	typedef union packed
	{
		tileHalvesT                                  halves;
		logic [`ICACHE_TILE_BITS/16-1:0][15:0]       words;
	} tileViewT;

	typedef struct packed
	{
		logic [`ICACHE_HALF_BITS-1:0]   data;
		logic                           hit;
		logic [`ICACHE_TAG_BITS-1:0]    tag;	// requested, not stored
		logic [`ICACHE_INDEX_BITS-1:0]  index;
	} bankLookupT;

	typedef struct packed
	{
		logic                           en;
		logic [`ICACHE_INDEX_BITS-1:0]  index;
		logic [`ICACHE_TAG_BITS-1:0]    tag;
		logic [`ICACHE_HALF_BITS-1:0]   data;
	} bankFillT;

endpackage

//--- rtl/icacheBank.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module icacheBank
	import icachePkg::*;
(
	input  logic                           clock,
	input  logic                           arstN,
	input  logic [`ICACHE_INDEX_BITS-1:0]  lookIndex,
	input  logic [`ICACHE_TAG_BITS-1:0]    lookTag,
	input  bankFillT                       fill,
	output bankLookupT                     result
);

	localparam int lineCount = 1 << `ICACHE_INDEX_BITS;

	logic [`ICACHE_HALF_BITS-1:0]  dataMem [lineCount];
	logic [`ICACHE_TAG_BITS-1:0]   tagMem [lineCount];
	logic [lineCount-1:0]          validBits;

	logic [`ICACHE_INDEX_BITS-1:0] regIndex;	// requested index
	logic [`ICACHE_TAG_BITS-1:0]   regTag;		// requested tag
	logic [`ICACHE_HALF_BITS-1:0]  regData;
	logic [`ICACHE_TAG_BITS-1:0]   regStoredTag;
	logic                          regValid;
	logic                          fillBypass;

	// a fill landing on the looked-up line is forwarded
	assign fillBypass = fill.en && (fill.index == lookIndex);

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			validBits <= '0;
			regIndex  <= '0;
			regTag    <= '0;
			regValid  <= 1'b0;
		end
		else
		begin
			if (fill.en)
				validBits[fill.index] <= 1'b1;
			regIndex <= lookIndex;
			regTag   <= lookTag;
			regValid <= fillBypass ? 1'b1 : validBits[lookIndex];
		end
	end

	// array writes and the registered read
	always_ff @(posedge clock)
	begin
		if (fill.en)
		begin
			dataMem[fill.index] <= fill.data;
			tagMem[fill.index]  <= fill.tag;
		end
		if (fillBypass)
		begin
			regData      <= fill.data;
			regStoredTag <= fill.tag;
		end
		else
		begin
			regData      <= dataMem[lookIndex];
			regStoredTag <= tagMem[lookIndex];
		end
	end

	assign result.data  = regData;
	assign result.hit   = regValid && (regStoredTag == regTag);
	assign result.tag   = regTag;
	assign result.index = regIndex;

	// refill engine spends a finish cycle after every write
	fillSinglePulse: assert property (@(posedge clock) disable iff (!arstN)
		fill.en |=> !fill.en);

endmodule

//--- rtl/fetchAligner.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module fetchAligner
	import icachePkg::*;
(
	input  bankLookupT                     evenBank,
	input  bankLookupT                     oddBank,
	input  logic [1:0]                     wordSel,
	input  logic                           swapHalves,
	input  logic                           fault,
	output logic [`ICACHE_HALF_BITS-1:0]   window,
	output logic [1:0]                     step,
	output fetchStatusT                    status
);

	localparam bit ops48 = `ICACHE_OPS48;

	tileViewT     tile;
	logic [15:0]  firstWord;

	// odd-half start puts the next tile's even half on top
	always_comb
	begin
		if (swapHalves)
		begin
			tile.halves.lo = oddBank.data;
			tile.halves.hi = evenBank.data;
		end
		else
		begin
			tile.halves.lo = evenBank.data;
			tile.halves.hi = oddBank.data;
		end
	end

	always_comb
	begin
		for (int i = 0; i < 4; i++)
			window[i*16 +: 16] = tile.words[{1'b0, wordSel} + 3'(i)];	// wordSel+3 tops out at 6
	end

	assign firstWord = tile.words[wordSel];

	always_comb
	begin
		if (ops48 && (firstWord[15:13] == 3'b111) && (firstWord[11:10] == 2'b01))
			step = 2'd3;	// 48-bit form
		else if (firstWord[15:13] == 3'b111)
			step = 2'd2;
		else
			step = 2'd1;

		if (fault)
			status = statusFault;
		else if (evenBank.hit && oddBank.hit)
			status = statusOk;
		else
			status = statusHold;
	end

endmodule

//--- rtl/tileRefill.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module tileRefill
	import icachePkg::*;
(
	input  logic        clock,
	input  logic        arstN,
	input  bankLookupT  evenBank,
	input  bankLookupT  oddBank,
	input  wbRspT       bus,
	output wbReqT       busReq,
	output bankFillT    evenFill,
	output bankFillT    oddFill,
	output logic        fault
);

	typedef enum logic [1:0]
	{
		stIdle,
		stRequest,
		stFinish
	} refillStateT;

	refillStateT                    state;
	logic                           started;	// first lookup after reset is done
	logic                           busActive;
	logic                           fillEn;
	logic [`ICACHE_TAG_BITS-1:0]    tileTag;
	logic [`ICACHE_INDEX_BITS-1:0]  tileIndex;
	tileViewT                       fillTile;
	bankLookupT                     missBank;
	logic                           anyMiss;

	assign anyMiss  = !evenBank.hit || !oddBank.hit;
	assign missBank = !evenBank.hit ? evenBank : oddBank;	// even bank first

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state     <= stIdle;
			started   <= 1'b0;
			busActive <= 1'b0;
			fillEn    <= 1'b0;
			fault     <= 1'b0;
			tileTag   <= '0;
			tileIndex <= '0;
		end
		else
		begin
			started <= 1'b1;
			case (state)
				stIdle:
				begin
					if (started && anyMiss)
					begin
						tileTag   <= missBank.tag;
						tileIndex <= missBank.index;
						busActive <= 1'b1;
						state     <= stRequest;
					end
				end
				stRequest:
				begin
					if (bus.ack)
					begin
						busActive <= 1'b0;
						fillEn    <= 1'b1;
						state     <= stFinish;
					end
					else if (bus.err)
					begin
						busActive <= 1'b0;
						fault     <= 1'b1;	// tile left invalid
						state     <= stFinish;
					end
				end
				stFinish:
				begin
					// bank results are stale here, so no new miss is taken
					fillEn <= 1'b0;
					fault  <= 1'b0;
					state  <= stIdle;
				end
				default:
					state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == stRequest && bus.ack)
			fillTile <= tileViewT'(bus.dat);
	end

	assign busReq.cyc = busActive;
	assign busReq.stb = busActive;	// single beat so strobe spans the cycle
	assign busReq.adr = {tileTag, tileIndex, 4'b0000};

	assign evenFill.en    = fillEn;
	assign evenFill.index = tileIndex;
	assign evenFill.tag   = tileTag;
	assign evenFill.data  = fillTile.halves.lo;

	assign oddFill.en     = fillEn;
	assign oddFill.index  = tileIndex;
	assign oddFill.tag    = tileTag;
	assign oddFill.data   = fillTile.halves.hi;

	// memory answers only inside a bus cycle
	rspOnlyInCycle: assert property (@(posedge clock) disable iff (!arstN)
		(bus.ack || bus.err) |-> busReq.cyc);

	adrHeldWhileWaiting: assert property (@(posedge clock) disable iff (!arstN)
		(busReq.stb && !bus.ack && !bus.err) |=> $stable(busReq.adr));

endmodule

//--- rtl/instrFetchCache.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module instrFetchCache
	import icachePkg::*;
(
	input  logic                           clock,
	input  logic                           arstN,
	input  logic [`ICACHE_ADDR_BITS-1:0]   pc,
	input  logic                           hold,
	input  wbRspT                          bus,
	output logic [`ICACHE_HALF_BITS-1:0]   window,
	output logic [1:0]                     step,
	output fetchStatusT                    status,
	output wbReqT                          busReq
);

	localparam int tileAddrBits = `ICACHE_ADDR_BITS - 4;

	logic [`ICACHE_ADDR_BITS-1:0]  addrReg;	// address behind the current lookup
	logic [`ICACHE_ADDR_BITS-1:0]  effAddr;
	logic [tileAddrBits-1:0]       oddTile;
	logic [tileAddrBits-1:0]       evenTile;
	bankLookupT                    evenResult;
	bankLookupT                    oddResult;
	bankFillT                      evenFill;
	bankFillT                      oddFill;
	logic                          refillFault;

	assign effAddr = hold ? addrReg : pc;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			addrReg <= '0;
		else
			addrReg <= effAddr;
	end

	assign oddTile  = effAddr[`ICACHE_ADDR_BITS-1:4];
	assign evenTile = effAddr[3] ? oddTile + 1'b1 : oddTile;	// window runs into next tile

	icacheBank evenBank_i
	(
		.clock     (clock),
		.arstN     (arstN),
		.lookIndex (evenTile[`ICACHE_INDEX_BITS-1:0]),
		.lookTag   (evenTile[tileAddrBits-1:`ICACHE_INDEX_BITS]),
		.fill      (evenFill),
		.result    (evenResult)
	);

	icacheBank oddBank_i
	(
		.clock     (clock),
		.arstN     (arstN),
		.lookIndex (oddTile[`ICACHE_INDEX_BITS-1:0]),
		.lookTag   (oddTile[tileAddrBits-1:`ICACHE_INDEX_BITS]),
		.fill      (oddFill),
		.result    (oddResult)
	);

	fetchAligner fetchAligner_i
	(
		.evenBank   (evenResult),
		.oddBank    (oddResult),
		.wordSel    (addrReg[2:1]),
		.swapHalves (addrReg[3]),
		.fault      (refillFault),
		.window     (window),
		.step       (step),
		.status     (status)
	);

	tileRefill tileRefill_i
	(
		.clock    (clock),
		.arstN    (arstN),
		.evenBank (evenResult),
		.oddBank  (oddResult),
		.bus      (bus),
		.busReq   (busReq),
		.evenFill (evenFill),
		.oddFill  (oddFill),
		.fault    (refillFault)
	);

endmodule

//--- verification/fetchTb.sv
`timescale 1ns/1ps
`include "icache_params.svh"

module fetchTb
	import icachePkg::*;
();

	localparam int timeoutCycles = 200;

	logic         clock;
	logic         arstN;
	logic [31:0]  pc;
	logic         hold;
	wbRspT        bus = '0;
	logic [63:0]  window;
	logic [1:0]   step;
	fetchStatusT  status;
	wbReqT        busReq;

	logic [31:0]  rngState = 32'd77;
	int           waitLeft = 0;	// cycles until the slave answers
	int           busCount = 0;	// Wishbone cycles started so far
	logic         cycSeen = 1'b0;
	logic [31:0]  adrLog [0:255];

	logic [27:0]  modelTile [0:63];	// tiles the cache should hold
	logic [63:0]  modelValid;

	int           testCount = 0;
	int           failCount = 0;
	int           errorCount = 0;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] v;
		v = x ^ (x << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// one memory word per halfword address
	function automatic logic [15:0] memWord(input logic [31:0] h);
		logic [31:0] v;
		v = xorshift32(h ^ 32'd77);
		return v[15:0];
	endfunction

	function automatic logic [1:0] lengthOf(input logic [15:0] w);
		if (`ICACHE_OPS48 && w[15:13] == 3'b111 && w[11:10] == 2'b01)
			return 2'd3;
		else if (w[15:13] == 3'b111)
			return 2'd2;
		else
			return 2'd1;
	endfunction

	function automatic logic tileCached(input logic [27:0] t);
		return modelValid[t[5:0]] && (modelTile[t[5:0]] == t);
	endfunction

	function automatic string behaviorName(input int code);
		case (code)
			1: return "coldMiss";
			2: return "hitAfterFill";
			3: return "tileCross";
			4: return "instrLength";
			5: return "holdEvict";
			6: return "busFault";
			default: return "unknown";
		endcase
	endfunction

	instrFetchCache dut_i
	(
		.clock  (clock),
		.arstN  (arstN),
		.pc     (pc),
		.hold   (hold),
		.bus    (bus),
		.window (window),
		.step   (step),
		.status (status),
		.busReq (busReq)
	);

	always #5 clock = ~clock;

	// Wishbone slave answering after 1 to 4 cycles
	always @(negedge clock)
	begin
		bus.ack = 1'b0;
		bus.err = 1'b0;
		if (arstN && busReq.cyc && busReq.stb)
		begin
			if (waitLeft == 0)
			begin
				rngState = xorshift32(rngState);
				waitLeft = 1 + int'(rngState % 32'd4);
			end
			waitLeft = waitLeft - 1;
			if (waitLeft == 0)
			begin
				if (busReq.adr[31:24] == 8'hF0)
					bus.err = 1'b1;
				else
					bus.ack = 1'b1;
				for (int i = 0; i < 8; i++)
					bus.dat[i*16 +: 16] = memWord({1'b0, busReq.adr[31:1]} + 32'(i));
			end
		end
	end

	// log each new bus cycle and its address
	always @(posedge clock)
	begin
		if (busReq.cyc && !cycSeen)
		begin
			adrLog[busCount[7:0]] <= busReq.adr;
			busCount <= busCount + 1;
		end
		cycSeen <= busReq.cyc;
	end

	task automatic fetchAndCheck(input int code, input logic [31:0] startPc,
		input logic holdFlag, input logic expectFault);
		string        name;
		logic [27:0]  needTile [2];
		int           needCount;
		int           expCycles;
		logic         stopped;
		logic [31:0]  expAdr;
		logic [63:0]  expWindow;
		logic [1:0]   expStep;
		fetchStatusT  expStatus;
		logic [63:0]  seenWindow;
		int           startBus;
		int           waited;
		int           errorsBefore;

		name = $sformatf("%s_%0d", behaviorName(code), testCount);
		errorsBefore = errorCount;
		needCount = startPc[3] ? 2 : 1;
		needTile[0] = startPc[31:4] + (startPc[3] ? 28'd1 : 28'd0);	// even bank tile first
		needTile[1] = startPc[31:4];
		expCycles = 0;
		expAdr = '0;
		stopped = 1'b0;
		for (int k = 0; k < needCount; k++)
			if (!stopped && !tileCached(needTile[k]))
			begin
				if (expCycles == 0)
					expAdr = {needTile[k], 4'h0};
				expCycles++;
				stopped = (needTile[k][27:20] == 8'hF0);
			end
		for (int k = 0; k < 4; k++)
			expWindow[k*16 +: 16] = memWord({1'b0, startPc[31:1]} + 32'(k));
		expStep = lengthOf(expWindow[15:0]);
		expStatus = expectFault ? statusFault : statusOk;

		startBus = busCount;
		pc = startPc;
		hold = 1'b0;
		@(negedge clock);
		waited = 0;
		while (status == statusHold && waited < timeoutCycles)
		begin
			hold = 1'b1;
			if (holdFlag)
				pc = startPc ^ 32'h0000_0F30;	// other tile that hold must ignore
			@(negedge clock);
			waited++;
		end

		if (status == statusHold)
		begin
			$display("test %s: status stayed hold for %0d cycles", name, timeoutCycles);
			errorCount++;
		end
		else if (status != expStatus)
		begin
			$display("MISMATCH %s status expected %s actual %s", name, expStatus.name(),
				status.name());
			errorCount++;
		end
		else if (!expectFault)
		begin
			if (window !== expWindow)
			begin
				$display("MISMATCH %s window expected %h actual %h", name, expWindow, window);
				errorCount++;
			end
			if (step !== expStep)
			begin
				$display("MISMATCH %s step expected %0d actual %0d", name, expStep, step);
				errorCount++;
			end
		end
		if (busCount - startBus != expCycles)
		begin
			$display("MISMATCH %s bus cycles expected %0d actual %0d", name, expCycles,
				busCount - startBus);
			errorCount++;
		end
		else if (expCycles > 0 && adrLog[startBus[7:0]] !== expAdr)
		begin
			$display("MISMATCH %s first adr expected %h actual %h", name, expAdr,
				adrLog[startBus[7:0]]);
			errorCount++;
		end

		if (holdFlag && status == statusOk)
		begin
			seenWindow = window;
			hold = 1'b1;
			pc = startPc ^ 32'h0000_0F30;
			@(negedge clock);
			if (window !== seenWindow || status != statusOk)
			begin
				$display("MISMATCH %s held window expected %h actual %h", name, seenWindow,
					window);
				errorCount++;
			end
		end

		// faulting tiles are never written
		for (int k = 0; k < needCount; k++)
			if (needTile[k][27:20] != 8'hF0)
			begin
				modelValid[needTile[k][5:0]] = 1'b1;
				modelTile[needTile[k][5:0]] = needTile[k];
			end

		testCount++;
		if (errorCount == errorsBefore)
			$display("test %s pc=%h: pass, %0d bus cycles", name, startPc, busCount - startBus);
		else
		begin
			failCount++;
			$display("test %s pc=%h: FAIL", name, startPc);
		end
	endtask

	initial
	begin
		int           fd;
		int           waited;
		int           code;
		int           holdFlag;
		int           faultFlag;
		int           fields;
		logic [31:0]  vecPc;
		string        line;

		clock = 1'b0;
		arstN = 1'b0;
		pc = '0;
		hold = 1'b0;
		modelValid = '0;
		repeat (4) @(negedge clock);
		arstN = 1'b1;

		// pc 0 after reset pulls in tile 0
		waited = 0;
		while (status != statusOk && waited < timeoutCycles)
		begin
			@(negedge clock);
			waited++;
		end
		if (status != statusOk)
		begin
			$display("status never became ok after reset");
			errorCount++;
		end
		modelValid[0] = 1'b1;
		modelTile[0] = '0;

		fd = $fopen("verification/fetch_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("could not open verification/fetch_vectors.txt");
			errorCount++;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() < 2 || line[0] == "#")
					continue;	// comment or blank
				fields = $sscanf(line, "%d %h %d %d", code, vecPc, holdFlag, faultFlag);
				if (fields == 4)
					fetchAndCheck(code, vecPc, holdFlag != 0, faultFlag != 0);
			end
			$fclose(fd);
		end

		$display("%0d tests, %0d failed, %0d errors", testCount, failCount, errorCount);
		if (errorCount == 0 && testCount > 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- verification/fetch_vectors.txt
# code: 1 cold miss, 2 hit, 3 tile crossing, 4 length, 5 hold and eviction, 6 bus fault
# columns: code pc(hex) hold-flag expected-fault
1 00001024 0 0
1 00003040 0 0
2 00001020 0 0
2 00001026 0 0
2 00003044 0 0
3 00002038 0 0
3 0000203c 0 0
3 0000102a 0 0
3 000013f8 0 0
4 00000094 0 0
4 00000084 0 0
4 0000009a 0 0
4 00000090 0 0
5 00001022 1 0
5 00005024 1 0
5 00001024 0 0
5 0000502c 1 0
6 f0000040 0 1
6 f0000040 0 1
6 00000040 0 0
6 f0000146 1 1

//--- vlog.f
+incdir+rtl
rtl/icachePkg.sv
rtl/icacheBank.sv
rtl/fetchAligner.sv
rtl/tileRefill.sv
rtl/instrFetchCache.sv
verification/fetchTb.sv

//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert -Wno-fatal
TOP      = fetchTb
FILELIST = vlog.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJDIR)
